//--- source/rx_buffer_pkg.sv
// Geometry of the receive buffer memory; sizes here are fixed for one 2 KiB buffer
package rx_buffer_pkg;

  // ----------------------------------------
  // Memory geometry
  // ----------------------------------------

  // Word address width, 256 words of 64 bits
  localparam int ADDR_WIDTH = 8;

  // Width of one RAM word
  localparam int WORD_WIDTH = 64;

  // Byte offset inside a word
  localparam int BYTE_SEL_WIDTH = 3;

  // Full byte address on the access port
  localparam int BYTE_ADDR_WIDTH = ADDR_WIDTH + BYTE_SEL_WIDTH;

  // ----------------------------------------
  // Types
  // ----------------------------------------

  typedef logic [ADDR_WIDTH-1:0]      word_addr_t;
  typedef logic [BYTE_ADDR_WIDTH-1:0] byte_addr_t;

  // Byte 0 of a word sits in bits 63:56
  typedef logic [WORD_WIDTH-1:0]      word_t;

endpackage

//--- source/rx_access_pkg.sv
// Access port encodings and sequencer states; word sizes 4 to 7 have no name and are illegal
package rx_access_pkg;

  // ----------------------------------------
  // Access word size
  // ----------------------------------------

  // Encoded as on the parser's wordsize bus
  typedef enum logic [2:0] {
    SIZE_8  = 3'd0,
    SIZE_16 = 3'd1,
    SIZE_32 = 3'd2,
    SIZE_64 = 3'd3
  } access_size_e;

  // ----------------------------------------
  // Sequencer state
  // ----------------------------------------

  // DLY states cover the RAM input register
  typedef enum logic [2:0] {
    ST_IDLE        = 3'd0,
    ST_LOAD        = 3'd1,
    ST_READ_DLY    = 3'd2,
    ST_READ_ONE    = 3'd3,
    ST_SPAN_DLY    = 3'd4,
    ST_SPAN_FIRST  = 3'd5,
    ST_SPAN_SECOND = 3'd6
  } ctrl_state_e;

endpackage

//--- source/rx_buffer_ram.sv
// Two cycles from address to data; read-first, so a read in the write cycle sees old data
`timescale 1ns/1ns

module rx_buffer_ram (
  input  logic                      i_clk,
  input  logic                      i_areset,
  input  rx_buffer_pkg::word_addr_t i_addr,
  input  logic                      i_write,
  input  rx_buffer_pkg::word_t      i_wr_data,
  output rx_buffer_pkg::word_t      o_rd_data
);
  import rx_buffer_pkg::*;

  logic       sync_meta;
  logic       sync_reset;
  word_addr_t addr_q;
  logic       write_q;
  word_t      wr_data_q;
  word_t      mem [0:(1 << ADDR_WIDTH)-1];

  // ----------------------------------------
  // Reset synchronizer
  // ----------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      sync_meta  <= 1'b1;
      sync_reset <= 1'b1;
    end else begin
      sync_meta  <= 1'b0;
      sync_reset <= sync_meta;
    end
  end

  // ----------------------------------------
  // Input stage
  // ----------------------------------------

  always_ff @(posedge i_clk) begin
    if (sync_reset) begin
      addr_q  <= '0;
      write_q <= 1'b0;
    end else begin
      addr_q  <= i_addr;
      write_q <= i_write;
    end
  end

  always_ff @(posedge i_clk) begin
    wr_data_q <= i_wr_data;
  end

  // Array with registered read
  always_ff @(posedge i_clk) begin
    if (write_q) begin
      mem[addr_q] <= wr_data_q;
    end
    o_rd_data <= mem[addr_q];
  end

  // A word written and then read back must come out defined
  a_read_after_write : assert property (@(posedge i_clk) disable iff (i_areset)
    write_q ##1 (!write_q && addr_q == $past(addr_q)) |=> !$isunknown(o_rd_data));

endmodule

//--- source/rx_fifo_loader.sv
// One packet per start pulse; FIFO data must not be valid in the start cycle itself
`timescale 1ns/1ns

module rx_fifo_loader (
  input  logic                      i_clk,
  input  logic                      i_areset,
  input  logic                      i_start,
  input  logic                      i_fifo_empty,
  input  logic                      i_fifo_rd_valid,
  input  rx_buffer_pkg::word_t      i_fifo_rd_data,
  output logic                      o_wr_en,
  output rx_buffer_pkg::word_addr_t o_wr_addr,
  output rx_buffer_pkg::word_t      o_wr_data,
  output logic                      o_load_done,
  output logic                      o_packet_read
);
  import rx_buffer_pkg::*;

  logic       loading_q;
  word_addr_t count_q;

  // ----------------------------------------
  // Write side
  // ----------------------------------------

  // Each valid FIFO word lands at the next word address
  assign o_wr_en   = loading_q && i_fifo_rd_valid;
  assign o_wr_addr = count_q;
  assign o_wr_data = i_fifo_rd_data;

  // End of packet: FIFO drained and nothing in flight
  assign o_load_done = loading_q && i_fifo_empty && !i_fifo_rd_valid;

  // ----------------------------------------
  // Load state
  // ----------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      loading_q     <= 1'b0;
      count_q       <= '0;
      o_packet_read <= 1'b0;
    end else begin
      o_packet_read <= o_load_done;
      if (i_start) begin
        loading_q <= 1'b1;
        count_q   <= '0;
      end else if (o_load_done) begin
        loading_q <= 1'b0;
      end else if (o_wr_en) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // The FIFO only delivers words after a start and before the end of the packet
  a_valid_only_when_loading : assert property (@(posedge i_clk) disable iff (i_areset)
    !loading_q |-> !i_fifo_rd_valid);

endmodule

//--- source/rx_buffer_ctrl.sv
// One read in flight at a time; reads are only taken in idle, illegal sizes are dropped silently
`timescale 1ns/1ns

module rx_buffer_ctrl (
  input  logic                        i_clk,
  input  logic                        i_areset,
  input  logic                        i_parser_busy,
  input  logic                        i_packet_available,
  input  logic                        i_fifo_empty,
  input  logic                        i_rd_en,
  input  rx_buffer_pkg::byte_addr_t   i_byte_addr,
  input  rx_access_pkg::access_size_e i_size,
  input  logic                        i_load_done,
  input  logic                        i_wr_en,
  input  rx_buffer_pkg::word_addr_t   i_wr_addr,
  output logic                        o_load_start,
  output rx_buffer_pkg::word_addr_t   o_ram_addr,
  output logic                        o_ram_write,
  output logic                        o_req,
  output logic                        o_take_first,
  output logic                        o_take_word
);
  import rx_buffer_pkg::*;
  import rx_access_pkg::*;

  ctrl_state_e               state_q;
  ctrl_state_e               state_d;
  word_addr_t                word_q;
  word_addr_t                req_word;
  logic [BYTE_SEL_WIDTH-1:0] req_offset;
  logic                      size_ok;
  logic                      spans;

  assign req_word   = i_byte_addr[BYTE_ADDR_WIDTH-1:BYTE_SEL_WIDTH];
  assign req_offset = i_byte_addr[BYTE_SEL_WIDTH-1:0];

  // ----------------------------------------
  // Request decode
  // ----------------------------------------

  // A field spans when it runs past byte 7 of its first word
  always_comb begin
    size_ok = 1'b1;
    spans   = 1'b0;
    case (i_size)
      SIZE_8:  spans = 1'b0;
      SIZE_16: spans = (req_offset == 3'd7);
      SIZE_32: spans = (req_offset >= 3'd5);
      SIZE_64: spans = (req_offset != 3'd0);
      default: size_ok = 1'b0;
    endcase
  end

  // Loading wins over a read in the same cycle
  assign o_load_start = (state_q == ST_IDLE) && !i_parser_busy &&
                        i_packet_available && !i_fifo_empty;
  assign o_req        = (state_q == ST_IDLE) && !o_load_start && i_rd_en && size_ok;
  assign o_take_first = (state_q == ST_SPAN_FIRST);
  assign o_take_word  = (state_q == ST_READ_ONE) || (state_q == ST_SPAN_SECOND);

  // ----------------------------------------
  // Sequencer
  // ----------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (o_load_start) begin
          state_d = ST_LOAD;
        end else if (o_req) begin
          state_d = spans ? ST_SPAN_DLY : ST_READ_DLY;
        end
      end
      ST_LOAD: begin
        if (i_load_done) begin
          state_d = ST_IDLE;
        end
      end
      ST_READ_DLY:    state_d = ST_READ_ONE;
      ST_READ_ONE:    state_d = ST_IDLE;
      ST_SPAN_DLY:    state_d = ST_SPAN_FIRST;
      ST_SPAN_FIRST:  state_d = ST_SPAN_SECOND;
      ST_SPAN_SECOND: state_d = ST_IDLE;
      default:        state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state_q <= ST_IDLE;
      word_q  <= '0;
    end else begin
      state_q <= state_d;
      if (o_req) begin
        word_q <= req_word;
      end
    end
  end

  // RAM port takes the loader address while loading and the second word after the first
  always_comb begin
    o_ram_write = 1'b0;
    case (state_q)
      ST_IDLE: o_ram_addr = req_word;
      ST_LOAD: begin
        o_ram_addr  = i_wr_addr;
        o_ram_write = i_wr_en;
      end
      ST_SPAN_DLY: o_ram_addr = word_q + 1'b1;
      default:     o_ram_addr = word_q;
    endcase
  end

  // Loader writes only reach the RAM while the sequencer is loading
  a_write_in_load : assert property (@(posedge i_clk) disable iff (i_areset)
    i_wr_en |-> state_q == ST_LOAD);

endmodule

//--- source/rx_access_aligner.sv
// Big-endian fields, right-justified in 64 bits; output data only changes with a dv pulse
`timescale 1ns/1ns

module rx_access_aligner (
  input  logic                                     i_clk,
  input  logic                                     i_areset,
  input  logic                                     i_req,
  input  logic [rx_buffer_pkg::BYTE_SEL_WIDTH-1:0] i_offset,
  input  rx_access_pkg::access_size_e              i_size,
  input  logic                                     i_take_first,
  input  logic                                     i_take_word,
  input  rx_buffer_pkg::word_t                     i_ram_data,
  output logic                                     o_wait,
  output logic                                     o_rd_dv,
  output rx_buffer_pkg::word_t                     o_rd_data
);
  import rx_buffer_pkg::*;
  import rx_access_pkg::*;

  // Bit counts up to a full word
  typedef logic [$clog2(WORD_WIDTH):0] shift_t;

  logic [BYTE_SEL_WIDTH-1:0] offset_q;
  access_size_e              size_q;
  logic                      span_q;
  word_t                     upper_q;
  shift_t                    size_bits;
  shift_t                    off_bits;
  shift_t                    low_bits;
  word_t                     field_one;
  word_t                     tail_first;
  word_t                     field_span;

  // ----------------------------------------
  // Field geometry
  // ----------------------------------------

  always_comb begin
    case (size_q)
      SIZE_8:  size_bits = shift_t'(8);
      SIZE_16: size_bits = shift_t'(16);
      SIZE_32: size_bits = shift_t'(32);
      default: size_bits = shift_t'(WORD_WIDTH);
    endcase
  end

  assign off_bits = shift_t'({offset_q, 3'b000});

  // Bits of a span that come from the second word
  assign low_bits = size_bits + off_bits - shift_t'(WORD_WIDTH);

  // Drop the bytes before the offset, then right-justify
  assign field_one = (i_ram_data << off_bits) >> (shift_t'(WORD_WIDTH) - size_bits);

  // Tail of the first word, moved up to make room for the low part
  assign tail_first = ((i_ram_data << off_bits) >> off_bits) << low_bits;

  // Head of the second word fills the low bits
  assign field_span = upper_q | (i_ram_data >> (shift_t'(WORD_WIDTH) - low_bits));

  // ----------------------------------------
  // Request and handshake state
  // ----------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      offset_q <= '0;
      size_q   <= SIZE_8;
      span_q   <= 1'b0;
      o_wait   <= 1'b0;
      o_rd_dv  <= 1'b0;
    end else begin
      o_rd_dv <= i_take_word;
      if (i_req) begin
        offset_q <= i_offset;
        size_q   <= i_size;
        o_wait   <= 1'b1;
      end else if (i_take_word) begin
        o_wait <= 1'b0;
      end
      if (i_take_first) begin
        span_q <= 1'b1;
      end else if (i_take_word) begin
        span_q <= 1'b0;
      end
    end
  end

  // Data path
  always_ff @(posedge i_clk) begin
    if (i_take_first) begin
      upper_q <= tail_first;
    end
    if (i_take_word) begin
      o_rd_data <= span_q ? field_span : field_one;
    end
  end

  a_dv_not_waiting : assert property (@(posedge i_clk) disable iff (i_areset)
    !(o_rd_dv && o_wait));

endmodule

//--- source/nts_rx_buffer.sv
// Receive buffer top; the parser must not raise rd_en while wait is high
`timescale 1ns/1ns

module nts_rx_buffer (
  input  logic                      i_clk,
  input  logic                      i_areset,
  input  logic                      i_parser_busy,
  input  logic                      i_dispatch_packet_available,
  input  logic                      i_dispatch_fifo_empty,
  input  logic                      i_dispatch_fifo_rd_valid,
  input  rx_buffer_pkg::word_t      i_dispatch_fifo_rd_data,
  output logic                      o_dispatch_fifo_rd_start,
  output logic                      o_dispatch_packet_read,
  input  logic                      i_access_port_rd_en,
  input  rx_buffer_pkg::byte_addr_t i_access_port_addr,
  input  logic [2:0]                i_access_port_wordsize,
  output logic                      o_access_port_wait,
  output logic                      o_access_port_rd_dv,
  output rx_buffer_pkg::word_t      o_access_port_rd_data
);
  import rx_buffer_pkg::*;
  import rx_access_pkg::*;

  access_size_e              access_size;
  logic [BYTE_SEL_WIDTH-1:0] access_offset;
  logic                      load_done;
  logic                      wr_en;
  word_addr_t                wr_addr;
  word_t                     wr_data;
  word_addr_t                ram_addr;
  logic                      ram_write;
  word_t                     ram_rd_data;
  logic                      req;
  logic                      take_first;
  logic                      take_word;

  assign access_size   = access_size_e'(i_access_port_wordsize);
  assign access_offset = i_access_port_addr[BYTE_SEL_WIDTH-1:0];

  rx_buffer_ram u_ram (
    .i_clk     (i_clk),
    .i_areset  (i_areset),
    .i_addr    (ram_addr),
    .i_write   (ram_write),
    .i_wr_data (wr_data),
    .o_rd_data (ram_rd_data)
  );

  rx_fifo_loader u_loader (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_start         (o_dispatch_fifo_rd_start),
    .i_fifo_empty    (i_dispatch_fifo_empty),
    .i_fifo_rd_valid (i_dispatch_fifo_rd_valid),
    .i_fifo_rd_data  (i_dispatch_fifo_rd_data),
    .o_wr_en         (wr_en),
    .o_wr_addr       (wr_addr),
    .o_wr_data       (wr_data),
    .o_load_done     (load_done),
    .o_packet_read   (o_dispatch_packet_read)
  );

  rx_buffer_ctrl u_ctrl (
    .i_clk              (i_clk),
    .i_areset           (i_areset),
    .i_parser_busy      (i_parser_busy),
    .i_packet_available (i_dispatch_packet_available),
    .i_fifo_empty       (i_dispatch_fifo_empty),
    .i_rd_en            (i_access_port_rd_en),
    .i_byte_addr        (i_access_port_addr),
    .i_size             (access_size),
    .i_load_done        (load_done),
    .i_wr_en            (wr_en),
    .i_wr_addr          (wr_addr),
    .o_load_start       (o_dispatch_fifo_rd_start),
    .o_ram_addr         (ram_addr),
    .o_ram_write        (ram_write),
    .o_req              (req),
    .o_take_first       (take_first),
    .o_take_word        (take_word)
  );

  rx_access_aligner u_aligner (
    .i_clk        (i_clk),
    .i_areset     (i_areset),
    .i_req        (req),
    .i_offset     (access_offset),
    .i_size       (access_size),
    .i_take_first (take_first),
    .i_take_word  (take_word),
    .i_ram_data   (ram_rd_data),
    .o_wait       (o_access_port_wait),
    .o_rd_dv      (o_access_port_rd_dv),
    .o_rd_data    (o_access_port_rd_data)
  );

endmodule

//--- verification/rx_buffer_tb.sv
// Loads one 12-word packet, then reads it back; reads stay inside the packet and never wrap
`timescale 1ns/1ns

module rx_buffer_tb;
  import rx_buffer_pkg::*;
  import rx_access_pkg::*;

  localparam int PACKET_WORDS   = 12;
  localparam int RESET_CYCLES   = 16;
  localparam int LOAD_CYCLES    = 8 + PACKET_WORDS + 16;
  localparam int READ_CYCLES    = 6;
  localparam int ALIGNED_READS  = 45;
  localparam int SPAN_READS     = 33;
  localparam int TEST_CYCLES    = RESET_CYCLES + 8 + LOAD_CYCLES +
                                  (ALIGNED_READS + SPAN_READS) * READ_CYCLES +
                                  4 * (8 + READ_CYCLES);
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic        i_clk;
  logic        i_areset;
  logic        i_parser_busy;
  logic        i_dispatch_packet_available;
  logic        i_dispatch_fifo_empty;
  logic        i_dispatch_fifo_rd_valid;
  word_t       i_dispatch_fifo_rd_data;
  logic        o_dispatch_fifo_rd_start;
  logic        o_dispatch_packet_read;
  logic        i_access_port_rd_en;
  byte_addr_t  i_access_port_addr;
  logic [2:0]  i_access_port_wordsize;
  logic        o_access_port_wait;
  logic        o_access_port_rd_dv;
  word_t       o_access_port_rd_data;

  word_t       ref_mem [0:PACKET_WORDS-1];
  word_t       exp_data;
  logic        exp_span;
  logic        exp_legal;
  logic        quiet_check;
  logic [31:0] lfsr;
  int          error_count;
  int          read_count;
  int          start_count;
  int          packet_read_count;
  int          cycle_count;
  int          errors_before;

  nts_rx_buffer DUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  a_quiet : assert property (@(posedge i_clk) (i_areset || quiet_check) |->
    !o_access_port_wait && !o_access_port_rd_dv && !o_dispatch_packet_read &&
    !o_dispatch_fifo_rd_start)
    else begin
      $display({"Error: o_access_port_wait %h o_access_port_rd_dv %h ",
                "o_dispatch_packet_read %h o_dispatch_fifo_rd_start %h, expected all 0"},
               $sampled(o_access_port_wait), $sampled(o_access_port_rd_dv),
               $sampled(o_dispatch_packet_read), $sampled(o_dispatch_fifo_rd_start));
      error_count++;
    end

  a_busy_blocks_load : assert property (@(posedge i_clk) disable iff (i_areset)
    i_parser_busy |-> !o_dispatch_fifo_rd_start)
    else begin
      $display("Load started while the parser was busy");
      error_count++;
    end

  a_packet_read_pulse : assert property (@(posedge i_clk) disable iff (i_areset)
    o_dispatch_packet_read |=> !o_dispatch_packet_read)
    else begin
      $display("Packet read pulse lasted more than one cycle");
      error_count++;
    end

  a_single_timing : assert property (@(posedge i_clk) disable iff (i_areset)
    (i_access_port_rd_en && exp_legal && !exp_span) |=>
      (o_access_port_wait && !o_access_port_rd_dv) ##1
      (o_access_port_wait && !o_access_port_rd_dv) ##1
      (o_access_port_rd_dv && !o_access_port_wait) ##1 !o_access_port_rd_dv)
    else begin
      $display("Single-word read: wait or data valid came at the wrong time");
      error_count++;
    end

  a_span_timing : assert property (@(posedge i_clk) disable iff (i_areset)
    (i_access_port_rd_en && exp_legal && exp_span) |=>
      (o_access_port_wait && !o_access_port_rd_dv) ##1
      (o_access_port_wait && !o_access_port_rd_dv) ##1
      (o_access_port_wait && !o_access_port_rd_dv) ##1
      (o_access_port_rd_dv && !o_access_port_wait) ##1 !o_access_port_rd_dv)
    else begin
      $display("Spanning read: wait or data valid came at the wrong time");
      error_count++;
    end

  a_illegal_ignored : assert property (@(posedge i_clk) disable iff (i_areset)
    (i_access_port_rd_en && !exp_legal) |=>
      (!o_access_port_wait && !o_access_port_rd_dv) ##1
      (!o_access_port_wait && !o_access_port_rd_dv) ##1
      (!o_access_port_wait && !o_access_port_rd_dv) ##1
      (!o_access_port_wait && !o_access_port_rd_dv))
    else begin
      $display("Read with an illegal word size raised wait or data valid");
      error_count++;
    end

  a_read_data : assert property (@(posedge i_clk) disable iff (i_areset)
    o_access_port_rd_dv |-> o_access_port_rd_data == exp_data)
    else begin
      $display("Error: o_access_port_rd_data = %h, expected %h",
               $sampled(o_access_port_rd_data), $sampled(exp_data));
      error_count++;
    end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  // Galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 32'h8020_0003;
    return n;
  endfunction

  // Byte A sits at bits 63-8k:56-8k of word A/8 where k is A mod 8
  function automatic word_t expected_field(input int addr, input int nbytes);
    word_t result;
    int    a;
    result = '0;
    for (int k = 0; k < nbytes; k++) begin
      a = addr + k;
      result = (result << 8) | ((ref_mem[a / 8] >> (56 - 8 * (a % 8))) & 64'hff);
    end
    return result;
  endfunction

  task automatic check_read(input int addr, input access_size_e size);
    int nbytes;
    int waited;
    nbytes = 1 << int'(size);
    @(posedge i_clk);
    i_access_port_rd_en    <= 1'b1;
    i_access_port_addr     <= byte_addr_t'(addr);
    i_access_port_wordsize <= size;
    exp_legal              <= 1'b1;
    exp_span               <= ((addr % 8) + nbytes) > 8;
    exp_data               <= expected_field(addr, nbytes);
    read_count++;
    @(posedge i_clk);
    i_access_port_rd_en <= 1'b0;
    waited = 0;
    do begin
      @(posedge i_clk);
      waited++;
    end while (!o_access_port_rd_dv && waited < 8);
    if (!o_access_port_rd_dv) begin
      $display("No data valid for the read at byte address %h", addr);
      error_count++;
    end
  endtask

  task automatic send_illegal_read(input int addr, input logic [2:0] code);
    @(posedge i_clk);
    i_access_port_rd_en    <= 1'b1;
    i_access_port_addr     <= byte_addr_t'(addr);
    i_access_port_wordsize <= code;
    exp_legal              <= 1'b0;
    exp_span               <= 1'b0;
    @(posedge i_clk);
    i_access_port_rd_en <= 1'b0;
    repeat (5) @(posedge i_clk);
  endtask

  task automatic report_test(input int num, input string name);
    repeat (2) @(posedge i_clk);
    if (error_count == errors_before) begin
      $display("Test %0d %s: passed", num, name);
    end else begin
      $display("Test %0d %s: failed with %0d errors", num, name, error_count - errors_before);
    end
    errors_before = error_count;
  endtask

  // Pulse counters for the load test
  always @(posedge i_clk) begin
    if (!i_areset) begin
      if (o_dispatch_fifo_rd_start) start_count++;
      if (o_dispatch_packet_read) packet_read_count++;
    end
  end

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  initial begin
    i_areset = 1'b1;
    i_parser_busy = 1'b0;
    i_dispatch_packet_available = 1'b0;
    i_dispatch_fifo_empty = 1'b1;
    i_dispatch_fifo_rd_valid = 1'b0;
    i_dispatch_fifo_rd_data = '0;
    i_access_port_rd_en = 1'b0;
    i_access_port_addr = '0;
    i_access_port_wordsize = '0;
    exp_data = '0;
    exp_span = 1'b0;
    exp_legal = 1'b1;
    quiet_check = 1'b0;
    error_count = 0;
    read_count = 0;
    start_count = 0;
    packet_read_count = 0;
    cycle_count = 0;
    errors_before = 0;
    lfsr = 32'd89790;
    for (int w = 0; w < PACKET_WORDS; w++) begin
      for (int b = 0; b < 64; b++) begin
        lfsr = lfsr_next(lfsr);
        ref_mem[w] = {ref_mem[w][62:0], lfsr[0]};
      end
    end

    repeat (RESET_CYCLES) @(posedge i_clk);
    i_areset    <= 1'b0;
    quiet_check <= 1'b1;
    repeat (4) @(posedge i_clk);
    quiet_check <= 1'b0;
    report_test(1, "reset state");

    // Packet waits while the parser is busy
    i_parser_busy               <= 1'b1;
    i_dispatch_packet_available <= 1'b1;
    i_dispatch_fifo_empty       <= 1'b0;
    repeat (8) @(posedge i_clk);
    i_parser_busy <= 1'b0;
    do @(posedge i_clk); while (!o_dispatch_fifo_rd_start);
    i_dispatch_packet_available <= 1'b0;
    for (int i = 0; i < PACKET_WORDS; i++) begin
      i_dispatch_fifo_rd_valid <= 1'b1;
      i_dispatch_fifo_rd_data  <= ref_mem[i];
      i_dispatch_fifo_empty    <= (i == PACKET_WORDS - 1);
      @(posedge i_clk);
    end
    i_dispatch_fifo_rd_valid <= 1'b0;
    do @(posedge i_clk); while (!o_dispatch_packet_read);
    repeat (4) @(posedge i_clk);
    assert (start_count == 1 && packet_read_count == 1)
      else begin
        $display("Error: rd_start count %h packet_read count %h, expected 1 and 1",
                 start_count, packet_read_count);
        error_count++;
      end
    while (DUT.u_ctrl.state_q != ST_IDLE) @(posedge i_clk);
    report_test(2, "packet load");

    for (int w = 0; w < 3; w++) begin
      for (int s = 0; s < 4; s++) begin
        for (int off = 0; off < 8; off += (1 << s)) begin
          check_read(w * 5 * 8 + off, access_size_e'(s));
        end
      end
    end
    report_test(3, "aligned reads");

    for (int w = 0; w < 3; w++) begin
      check_read(w * 4 * 8 + 7, SIZE_16);
      for (int off = 5; off < 8; off++) check_read(w * 4 * 8 + off, SIZE_32);
      for (int off = 1; off < 8; off++) check_read(w * 4 * 8 + off, SIZE_64);
    end
    report_test(4, "spanning reads");

    for (int code = 4; code < 8; code++) begin
      send_illegal_read(17 + code, 3'(code));
      check_read(17 + code, SIZE_32);
    end
    report_test(5, "illegal sizes");

    $display("Tests 5, reads %0d, errors %0d", read_count, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- all.f
source/rx_buffer_pkg.sv
source/rx_access_pkg.sv
source/rx_buffer_ram.sv
source/rx_fifo_loader.sv
source/rx_buffer_ctrl.sv
source/rx_access_aligner.sv
source/nts_rx_buffer.sv
verification/rx_buffer_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the receive buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal -f all.f \
  --top-module rx_buffer_tb -Mdir "$BUILD" -o rx_buffer_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD/rx_buffer_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
  exit 1
fi
exit 0
